/* project.f */
+incdir+include
+incdir+sim
logic/cache_pkg.sv
logic/tlb.sv
logic/tag_store.sv
logic/data_store.sv
logic/mem_port.sv
logic/cache_ctrl.sv
logic/cache_top.sv
sim/tb_cache.sv

/* Makefile */
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP       ?= tb_cache
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard include/*.svh logic/*.sv sim/*.sv sim/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides the result, not the exit status of the binary
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_stimulus.svh */
`ifndef TB_STIMULUS_SVH
`define TB_STIMULUS_SVH

  // ------------------------------
  // reference model
  // ------------------------------
  // translations, line tags and memory as the cache should see them
  cache_pkg::tlb_entry_t   model_tlb [`TLB_ENTRIES];
  logic [`PPN_W-1:0]       line_tag [`CACHE_LINES];
  logic                    line_ok [`CACHE_LINES];
  logic [31:0]             model_mem [MEM_WORDS];
  bit                      idx_used [`TLB_ENTRIES];
  int                      loaded_idx [$];

  function automatic logic tlb_maps(input logic [31:0] va);
    cache_pkg::tlb_entry_t e;
    e = model_tlb[va[`VPN_TAG_LSB-1:`PAGE_OFS_W]];
    return e.valid && (e.vtag == va[`VADDR_W-1:`VPN_TAG_LSB]);
  endfunction

  // word address inside a loaded page, kept low so lines get reused
  function automatic logic [31:0] mapped_va(input int idx);
    logic [31:0] va;
    va[31:16] = model_tlb[idx].vtag;
    va[15:10] = 6'(idx);
    va[9:2]   = 8'($urandom_range(0, 47));
    va[1:0]   = 2'b00;
    return va;
  endfunction

  task automatic load_entry(input logic [31:0] va, input logic [`PPN_W-1:0] ppn);
    cache_pkg::tlb_entry_t pte;
    int                    idx;
    bit                    ok;
    pte = '{valid: 1'b1, vtag: va[31:16], ppn: ppn};
    idx = int'(va[15:10]);
    wait_ready(ok);
    @(posedge CPU_CLK);
    tlb_we    <= 1'b1;
    tlb_vaddr <= va;
    tlb_pte   <= pte;
    @(posedge CPU_CLK);
    tlb_we    <= 1'b0;
    model_tlb[idx] = pte;
    if (!idx_used[idx])
    begin
      idx_used[idx] = 1'b1;
      loaded_idx.push_back(idx);
    end
  endtask

  // one cpu access, checked against the model
  task automatic run_access(input string name, input logic we, input logic [31:0] va,
                            input logic [31:0] wd);
    logic                    mapped;
    logic                    cached;
    logic [`PPN_W-1:0]       ppn;
    logic [`LINE_IDX_W-1:0]  line;
    logic [`MEM_ADDR_W-1:0]  pw;
    logic [31:0]             rd;
    logic                    ack;
    logic                    err;
    mapped = tlb_maps(va);
    ppn    = model_tlb[va[15:10]].ppn;
    line   = va[9:3];
    pw     = {ppn, va[9:2]};
    cached = mapped && line_ok[line] && (line_tag[line] == ppn);
    rd_addrs.delete();
    wr_addrs.delete();
    wr_datas.delete();
    cpu_cycle(we, va, wd, rd, ack, err);
    check_value({name, " err"}, 32'(!mapped), 32'(err));
    check_value({name, " ack"}, 32'(mapped), 32'(ack));
    check_value({name, " mem reads"}, 32'((mapped && !we && !cached) ? 2 : 0),
                32'(rd_addrs.size()));
    check_value({name, " mem writes"}, 32'((mapped && we) ? 1 : 0), 32'(wr_addrs.size()));
    if (mapped && !we)
    begin
      check_value({name, " data"}, model_mem[pw[15:0]], rd);
      if (rd_addrs.size() == 2)
      begin
        check_value({name, " even addr"}, 32'({pw[23:1], 1'b0}), 32'(rd_addrs[0]));
        check_value({name, " odd addr"}, 32'({pw[23:1], 1'b1}), 32'(rd_addrs[1]));
      end
      line_ok[line]  = 1'b1;
      line_tag[line] = ppn;
    end
    if (mapped && we && (wr_addrs.size() == 1))
    begin
      check_value({name, " write addr"}, 32'(pw), 32'(wr_addrs[0]));
      check_value({name, " write data"}, wd, wr_datas[0]);
    end
    if (mapped && we)
      model_mem[pw[15:0]] = wd;
  endtask

  // ------------------------------
  // random traffic
  // ------------------------------
  task automatic random_traffic(input int count);
    int          pick;
    int          idx;
    logic [31:0] va;
    logic [31:0] wd;
    for (int i = 0; i < count; i++)
    begin
      pick = int'($urandom_range(0, 99));
      idx  = loaded_idx[$urandom_range(0, loaded_idx.size() - 1)];
      va   = mapped_va(idx);
      wd   = $urandom;
      if (pick < 5)
        load_entry($urandom, 16'($urandom_range(0, 31)));
      else if (pick < 12)
        run_access("random va", pick[0], $urandom & 32'hffff_fffc, wd);
      else if (pick < 40)
        run_access("write", 1'b1, va, wd);
      else
      begin
        run_access("read", 1'b0, va, 32'h0);
        // same word again must come from the line just used
        if (pick < 60)
          run_access("hit reuse", 1'b0, va, 32'h0);
      end
    end
  endtask

`endif

/* sim/tb_cache.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module tb_cache;

  localparam int MEM_WORDS = 1 << 16;
  localparam int TIMEOUT   = 200;

  logic                    CPU_CLK;
  logic                    RST;
  logic                    cpu_cyc;
  logic                    cpu_stb;
  logic                    cpu_we;
  logic [`VADDR_W-1:0]     cpu_adr;
  logic [31:0]             cpu_dat_w;
  logic [31:0]             cpu_dat_r;
  logic                    cpu_ack;
  logic                    cpu_err;
  logic                    tlb_we;
  logic [`VADDR_W-1:0]     tlb_vaddr;
  cache_pkg::tlb_entry_t   tlb_pte;
  logic                    tlb_busy;
  logic                    mem_cyc;
  logic                    mem_stb;
  logic                    mem_we;
  logic [`MEM_ADDR_W-1:0]  mem_adr;
  logic [31:0]             mem_dat_w;
  logic [31:0]             mem_dat_r;
  logic                    mem_ack;

  // memory slave and its access log
  logic [31:0]             mem [MEM_WORDS];
  int                      wait_left;
  logic [`MEM_ADDR_W-1:0]  rd_addrs [$];
  logic [`MEM_ADDR_W-1:0]  wr_addrs [$];
  logic [31:0]             wr_datas [$];
  int                      value_errs;
  int                      timeouts;

  `include "tb_stimulus.svh"

  cache_top i_dut (.*);

  initial
  begin
    CPU_CLK = 1'b0;
    forever #10 CPU_CLK = ~CPU_CLK;
  end

  function automatic logic [31:0] fill_word(input logic [15:0] a);
    return {a ^ 16'h6b2d, ~a};
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("ERR %s expected %h actual %h", what, expected, actual);
      value_errs++;
    end
  endtask

  // ------------------------------
  // memory slave, 0 to 3 wait states
  // ------------------------------
  always @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      mem_ack   <= 1'b0;
      wait_left <= 0;
      for (int a = 0; a < MEM_WORDS; a++)
        mem[a] <= fill_word(16'(a));
    end
    else if (mem_ack)
      mem_ack <= 1'b0;
    else if (mem_cyc && mem_stb)
    begin
      if (wait_left != 0)
        wait_left <= wait_left - 1;
      else
      begin
        check_value("mem addr range", 32'h0, 32'(mem_adr[23:16]));
        mem_ack   <= 1'b1;
        wait_left <= int'($urandom_range(0, 3));
        if (mem_we)
        begin
          mem[mem_adr[15:0]] <= mem_dat_w;
          wr_addrs.push_back(mem_adr);
          wr_datas.push_back(mem_dat_w);
        end
        else
        begin
          mem_dat_r <= mem[mem_adr[15:0]];
          rd_addrs.push_back(mem_adr);
        end
      end
    end
  end

  task automatic wait_ready(output bit ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && (n < TIMEOUT))
    begin
      @(negedge CPU_CLK);
      ok = (tlb_busy === 1'b0);
      n++;
    end
    if (!ok)
    begin
      $display("timeout: tlb_busy stayed high for %0d cycles", TIMEOUT);
      timeouts++;
    end
  endtask

  // classic cycle, stb dropped on the edge after ack or err
  task automatic cpu_cycle(input logic we, input logic [31:0] va, input logic [31:0] wd,
                           output logic [31:0] rd, output logic ack, output logic err);
    int n;
    n   = 0;
    ack = 1'b0;
    err = 1'b0;
    rd  = '0;
    @(posedge CPU_CLK);
    cpu_cyc   <= 1'b1;
    cpu_stb   <= 1'b1;
    cpu_we    <= we;
    cpu_adr   <= va;
    cpu_dat_w <= wd;
    while (!(ack || err) && (n < TIMEOUT))
    begin
      @(negedge CPU_CLK);
      ack = cpu_ack;
      err = cpu_err;
      rd  = cpu_dat_r;
      n++;
    end
    if (!(ack || err))
    begin
      $display("timeout: no ack or err from the cache within %0d cycles", TIMEOUT);
      timeouts++;
    end
    else
      // controller is out of idle while it answers
      check_value("busy during access", 32'h1, 32'(tlb_busy));
    @(posedge CPU_CLK);
    cpu_cyc <= 1'b0;
    cpu_stb <= 1'b0;
    cpu_we  <= 1'b0;
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial
  begin
    bit          ok;
    logic [31:0] va_a;
    logic [31:0] va_b;
    logic [31:0] old_va;
    logic [15:0] ppn;
    void'($urandom(32'h81c4));
    RST        = 1'b0;
    cpu_cyc    = 1'b0;
    cpu_stb    = 1'b0;
    cpu_we     = 1'b0;
    cpu_adr    = '0;
    cpu_dat_w  = '0;
    tlb_we     = 1'b0;
    tlb_vaddr  = '0;
    tlb_pte    = '0;
    mem_dat_r  = '0;
    mem_ack    = 1'b0;
    value_errs = 0;
    timeouts   = 0;
    for (int a = 0; a < MEM_WORDS; a++)
      model_mem[a] = fill_word(16'(a));
    for (int i = 0; i < `TLB_ENTRIES; i++)
      model_tlb[i] = '0;
    for (int i = 0; i < `CACHE_LINES; i++)
      line_ok[i] = 1'b0;
    repeat (3) @(posedge CPU_CLK);
    RST <= 1'b1;

    // empty tlb after the sweep, every access must fault
    wait_ready(ok);
    check_value("reset idle outputs", 32'h0, 32'({cpu_ack, cpu_err, mem_cyc}));
    for (int i = 0; i < 4; i++)
      run_access("reset access", i[0], $urandom & 32'hffff_fffc, $urandom);

    for (int i = 0; i < 24; i++)
      load_entry($urandom, 16'($urandom_range(0, 31)));
    random_traffic(300);

    // two virtual pages on one physical page
    ppn  = 16'($urandom_range(0, 255));
    va_a = {16'($urandom), 6'd62, 8'($urandom_range(0, 255)), 2'b00};
    va_b = {16'($urandom), 6'd63, va_a[9:0]};
    load_entry(va_a, ppn);
    load_entry(va_b, ppn);
    run_access("alias read a", 1'b0, va_a, 32'h0);
    run_access("alias read b", 1'b0, va_b, 32'h0);
    run_access("alias write a", 1'b1, va_a, $urandom);
    run_access("alias read b", 1'b0, va_b, 32'h0);

    // entry replaced by another tag, old page must fault
    old_va = mapped_va(loaded_idx[0]);
    load_entry({old_va[31:16] ^ 16'h8001, old_va[15:0]}, 16'($urandom_range(0, 31)));
    run_access("stale read", 1'b0, old_va, 32'h0);
    run_access("stale write", 1'b1, old_va, $urandom);

    random_traffic(100);

    $display("errors: %0d value mismatches, %0d timeouts", value_errs, timeouts);
    if ((value_errs == 0) && (timeouts == 0))
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* logic/cache_top.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_top
(
  input  logic                      CPU_CLK,
  input  logic                      RST,
  // cpu wishbone slave
  input  logic                      cpu_cyc,
  input  logic                      cpu_stb,
  input  logic                      cpu_we,
  input  logic [`VADDR_W-1:0]       cpu_adr,
  input  logic [31:0]               cpu_dat_w,
  output logic [31:0]               cpu_dat_r,
  output logic                      cpu_ack,
  output logic                      cpu_err,
  // tlb load
  input  logic                      tlb_we,
  input  logic [`VADDR_W-1:0]       tlb_vaddr,
  input  cache_pkg::tlb_entry_t     tlb_pte,
  output logic                      tlb_busy,
  // memory wishbone master
  output logic                      mem_cyc,
  output logic                      mem_stb,
  output logic                      mem_we,
  output logic [`MEM_ADDR_W-1:0]    mem_adr,
  output logic [31:0]               mem_dat_w,
  input  logic [31:0]               mem_dat_r,
  input  logic                      mem_ack
);

  logic                       tlb_hit;
  logic [`PPN_W-1:0]          phys_page;
  logic                       line_hit;
  logic [31:0]                rd_word;
  logic                       sweep_done;
  logic [`VADDR_W-1:2]        lookup_idx;
  logic                       mem_start;
  cache_pkg::mem_req_t        mem_req;
  logic                       mem_done;
  logic [31:0]                mem_rdata;
  logic                       tag_we;
  cache_pkg::tag_entry_t      tag_wr;
  logic                       data_we;
  logic [`DATA_ADDR_W-1:0]    data_waddr;
  logic [31:0]                data_wdata;

  cache_ctrl u_ctrl
  (
    .CPU_CLK    (CPU_CLK),
    .RST        (RST),
    .cpu_cyc    (cpu_cyc),
    .cpu_stb    (cpu_stb),
    .cpu_we     (cpu_we),
    .cpu_adr    (cpu_adr),
    .cpu_dat_w  (cpu_dat_w),
    .tlb_hit    (tlb_hit),
    .phys_page  (phys_page),
    .line_hit   (line_hit),
    .rd_word    (rd_word),
    .mem_done   (mem_done),
    .mem_rdata  (mem_rdata),
    .sweep_done (sweep_done),
    .cpu_ack    (cpu_ack),
    .cpu_err    (cpu_err),
    .cpu_dat_r  (cpu_dat_r),
    .tlb_busy   (tlb_busy),
    .lookup_idx (lookup_idx),
    .mem_start  (mem_start),
    .mem_req    (mem_req),
    .tag_we     (tag_we),
    .tag_wr     (tag_wr),
    .data_we    (data_we),
    .data_waddr (data_waddr),
    .data_wdata (data_wdata)
  );

  // loads only land while the controller is idle
  tlb u_tlb
  (
    .CPU_CLK      (CPU_CLK),
    .RST          (RST),
    .lookup_vaddr (lookup_idx[`VADDR_W-1:`PAGE_OFS_W]),
    .load_we      (tlb_we && !tlb_busy),
    .load_vaddr   (tlb_vaddr[`VPN_TAG_LSB-1:`PAGE_OFS_W]),
    .load_pte     (tlb_pte),
    .tlb_hit      (tlb_hit),
    .phys_page    (phys_page),
    .sweep_done   (sweep_done)
  );

  // tag write index is the line part of the data write address
  tag_store u_tags
  (
    .CPU_CLK    (CPU_CLK),
    .RST        (RST),
    .rd_idx     (lookup_idx[`PAGE_OFS_W-1:`LINE_IDX_LSB]),
    .cmp_tag    (phys_page),
    .tag_we     (tag_we),
    .wr_idx     (data_waddr[`DATA_ADDR_W-1:1]),
    .tag_wr     (tag_wr),
    .sweep_done (sweep_done),
    .line_hit   (line_hit)
  );

  data_store u_data
  (
    .CPU_CLK (CPU_CLK),
    .rd_addr (lookup_idx[`PAGE_OFS_W-1:2]),
    .we      (data_we),
    .waddr   (data_waddr),
    .wdata   (data_wdata),
    .rdata   (rd_word)
  );

  mem_port u_mem
  (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .start     (mem_start),
    .req       (mem_req),
    .mem_ack   (mem_ack),
    .mem_dat_r (mem_dat_r),
    .mem_cyc   (mem_cyc),
    .mem_stb   (mem_stb),
    .mem_we    (mem_we),
    .mem_adr   (mem_adr),
    .mem_dat_w (mem_dat_w),
    .done      (mem_done),
    .rdata     (mem_rdata)
  );

endmodule

/* logic/cache_ctrl.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_ctrl
(
  input  logic                       CPU_CLK,
  input  logic                       RST,
  input  logic                       cpu_cyc,
  input  logic                       cpu_stb,
  input  logic                       cpu_we,
  input  logic [`VADDR_W-1:0]        cpu_adr,
  input  logic [31:0]                cpu_dat_w,
  input  logic                       tlb_hit,
  input  logic [`PPN_W-1:0]          phys_page,
  input  logic                       line_hit,
  input  logic [31:0]                rd_word,
  input  logic                       mem_done,
  input  logic [31:0]                mem_rdata,
  input  logic                       sweep_done,
  output logic                       cpu_ack,
  output logic                       cpu_err,
  output logic [31:0]                cpu_dat_r,
  output logic                       tlb_busy,
  output logic [`VADDR_W-1:2]        lookup_idx,
  output logic                       mem_start,
  output cache_pkg::mem_req_t        mem_req,
  output logic                       tag_we,
  output cache_pkg::tag_entry_t      tag_wr,
  output logic                       data_we,
  output logic [`DATA_ADDR_W-1:0]    data_waddr,
  output logic [31:0]                data_wdata
);

  cache_pkg::ctrl_state_e  state;
  cache_pkg::ctrl_state_e  state_nx;
  cache_pkg::cpu_req_t     req_q;
  logic [`PPN_W-1:0]       ppn_q;
  logic                    wr_hit_q;
  logic                    issued_q;
  logic [31:0]             refill_q [`WORDS_PER_LINE];
  logic [`LINE_IDX_W-1:0]  line_idx;
  logic                    take_req;
  logic                    in_refill;
  logic                    word_sel;

  // no new requests until the valid bits are swept
  assign take_req  = cpu_cyc && cpu_stb && sweep_done;
  assign line_idx  = req_q.vaddr[`PAGE_OFS_W-1:`LINE_IDX_LSB];
  assign in_refill = (state == cache_pkg::ST_REFILL0) || (state == cache_pkg::ST_REFILL1);

  // ------------------------------
  // next state
  // ------------------------------
  always_comb
  begin
    state_nx = state;
    case (state)
      cache_pkg::ST_IDLE:
        if (take_req)
          state_nx = cache_pkg::ST_LOOKUP;
      cache_pkg::ST_LOOKUP:
        if (!tlb_hit)
          state_nx = cache_pkg::ST_IDLE;
        else if (req_q.we)
          state_nx = cache_pkg::ST_WRITE;
        else if (line_hit)
          state_nx = cache_pkg::ST_IDLE;
        else
          state_nx = cache_pkg::ST_REFILL0;
      cache_pkg::ST_REFILL0:
        if (mem_done)
          state_nx = cache_pkg::ST_REFILL1;
      cache_pkg::ST_REFILL1:
        if (mem_done)
          state_nx = cache_pkg::ST_FILL_DONE;
      cache_pkg::ST_FILL_DONE:
        state_nx = cache_pkg::ST_RESP;
      cache_pkg::ST_WRITE:
        if (mem_done)
          state_nx = cache_pkg::ST_RESP;
      default:
        state_nx = cache_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state    <= cache_pkg::ST_IDLE;
      issued_q <= 1'b0;
    end
    else
    begin
      state    <= state_nx;
      // one memory request per state visit
      issued_q <= (state_nx == state) && (issued_q || mem_start);
    end
  end

  // request, translation and refill words
  always_ff @(posedge CPU_CLK)
  begin
    if ((state == cache_pkg::ST_IDLE) && take_req)
      req_q <= '{vaddr: cpu_adr, wdata: cpu_dat_w, we: cpu_we};
    if (state == cache_pkg::ST_LOOKUP)
    begin
      ppn_q    <= phys_page;
      wr_hit_q <= line_hit;
    end
    if (in_refill && mem_done)
      refill_q[state == cache_pkg::ST_REFILL1] <= mem_rdata;
  end

  // ------------------------------
  // memory requests
  // ------------------------------
  assign mem_start = !issued_q && (in_refill || (state == cache_pkg::ST_WRITE));

  always_comb
  begin
    mem_req.op   = req_q.we ? cache_pkg::MEM_WRITE : cache_pkg::MEM_READ;
    mem_req.data = req_q.wdata;
    if (state == cache_pkg::ST_WRITE)
      mem_req.addr = {ppn_q, req_q.vaddr[`PAGE_OFS_W-1:2]};
    else
      mem_req.addr = {ppn_q, line_idx, state == cache_pkg::ST_REFILL1};
  end

  // ------------------------------
  // store updates
  // ------------------------------
  // even word as it lands, odd word and tag together at the end
  assign word_sel   = (state == cache_pkg::ST_WRITE) ? req_q.vaddr[2]
                                                     : (state == cache_pkg::ST_FILL_DONE);
  assign data_we    = ((state == cache_pkg::ST_REFILL0) && mem_done)
                    || (state == cache_pkg::ST_FILL_DONE)
                    || ((state == cache_pkg::ST_WRITE) && wr_hit_q && !issued_q);
  assign data_waddr = {line_idx, word_sel};
  assign data_wdata = (state == cache_pkg::ST_WRITE) ? req_q.wdata : mem_rdata;
  assign tag_we     = (state == cache_pkg::ST_FILL_DONE);
  assign tag_wr     = '{valid: 1'b1, tag: ppn_q};

  // ------------------------------
  // cpu side
  // ------------------------------
  assign lookup_idx = (state == cache_pkg::ST_IDLE) ? cpu_adr[`VADDR_W-1:2]
                                                    : req_q.vaddr[`VADDR_W-1:2];
  assign cpu_ack    = ((state == cache_pkg::ST_LOOKUP) && tlb_hit && !req_q.we && line_hit)
                    || (state == cache_pkg::ST_RESP);
  assign cpu_err    = (state == cache_pkg::ST_LOOKUP) && !tlb_hit;
  assign cpu_dat_r  = (state == cache_pkg::ST_LOOKUP) ? rd_word : refill_q[req_q.vaddr[2]];
  assign tlb_busy   = (state != cache_pkg::ST_IDLE) || !sweep_done;

  a_ack_err_excl : assert property (@(posedge CPU_CLK) disable iff (!RST)
    !(cpu_ack && cpu_err));

  // a start is a single pulse, never repeated on the next cycle
  a_start_state : assert property (@(posedge CPU_CLK) disable iff (!RST)
    mem_start |-> (state inside {cache_pkg::ST_REFILL0, cache_pkg::ST_REFILL1,
                                 cache_pkg::ST_WRITE}) && !$past(mem_start));

endmodule

/* logic/mem_port.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module mem_port
(
  input  logic                      CPU_CLK,
  input  logic                      RST,
  input  logic                      start,
  input  cache_pkg::mem_req_t       req,
  input  logic                      mem_ack,
  input  logic [31:0]               mem_dat_r,
  output logic                      mem_cyc,
  output logic                      mem_stb,
  output logic                      mem_we,
  output logic [`MEM_ADDR_W-1:0]    mem_adr,
  output logic [31:0]               mem_dat_w,
  output logic                      done,
  output logic [31:0]               rdata
);

  cache_pkg::mem_req_t  req_q;
  logic                 active;
  logic                 accept;
  logic                 acked;

  assign accept = start && !active;
  assign acked  = active && mem_ack;

  // ------------------------------
  // bus cycle control
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      active <= 1'b0;
      done   <= 1'b0;
    end
    else
    begin
      // done lands with cyc already dropped
      done <= acked;
      if (accept)
        active <= 1'b1;
      else if (acked)
        active <= 1'b0;
    end
  end

  // request hold and read capture
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
      req_q <= req;
    if (acked && (req_q.op == cache_pkg::MEM_READ))
      rdata <= mem_dat_r;
  end

  assign mem_cyc   = active;
  assign mem_stb   = active;
  assign mem_we    = active && (req_q.op == cache_pkg::MEM_WRITE);
  assign mem_adr   = req_q.addr;
  assign mem_dat_w = req_q.data;

  a_adr_held : assert property (@(posedge CPU_CLK) disable iff (!RST)
    (mem_stb && !mem_ack) |=> (mem_stb && $stable(mem_adr)));

endmodule

/* logic/data_store.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module data_store
(
  input  logic                      CPU_CLK,
  input  logic [`DATA_ADDR_W-1:0]   rd_addr,
  input  logic                      we,
  input  logic [`DATA_ADDR_W-1:0]   waddr,
  input  logic [31:0]               wdata,
  output logic [31:0]               rdata
);

  // two words per line, line index on top
  logic [31:0] mem [`DATA_WORDS];

  // ------------------------------
  // write port
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (we)
      mem[waddr] <= wdata;
  end

  // ------------------------------
  // read port
  // ------------------------------
  // old data on a same-address write, as block RAM does
  always_ff @(posedge CPU_CLK)
  begin
    rdata <= mem[rd_addr];
  end

endmodule

/* logic/tag_store.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module tag_store
(
  input  logic                      CPU_CLK,
  input  logic                      RST,
  input  logic [`LINE_IDX_W-1:0]    rd_idx,
  input  logic [`PPN_W-1:0]         cmp_tag,
  input  logic                      tag_we,
  input  logic [`LINE_IDX_W-1:0]    wr_idx,
  input  cache_pkg::tag_entry_t     tag_wr,
  input  logic                      sweep_done,
  output logic                      line_hit
);

  cache_pkg::tag_entry_t   ram [`CACHE_LINES];
  cache_pkg::tag_entry_t   rd_q;
  logic [`LINE_IDX_W-1:0]  wipe_idx;

  // ------------------------------
  // invalidation pointer
  // ------------------------------
  // starts with the tlb counter and runs until sweep_done
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      wipe_idx <= '0;
    else if (!sweep_done)
      wipe_idx <= wipe_idx + 1'b1;
  end

  // ------------------------------
  // tag RAM
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!sweep_done)
      ram[wipe_idx] <= '0;
    else if (tag_we)
      ram[wr_idx] <= tag_wr;
  end

  always_ff @(posedge CPU_CLK)
  begin
    rd_q <= ram[rd_idx];
  end

  // compared against the page from the tlb in the same cycle
  assign line_hit = rd_q.valid && (rd_q.tag == cmp_tag);

endmodule

/* logic/tlb.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module tlb
(
  input  logic                                  CPU_CLK,
  input  logic                                  RST,
  input  logic [`VADDR_W-1:`PAGE_OFS_W]         lookup_vaddr,
  input  logic                                  load_we,
  input  logic [`VPN_TAG_LSB-1:`PAGE_OFS_W]     load_vaddr,
  input  cache_pkg::tlb_entry_t                 load_pte,
  output logic                                  tlb_hit,
  output logic [`PPN_W-1:0]                     phys_page,
  output logic                                  sweep_done
);

  cache_pkg::tlb_entry_t   ram [`TLB_ENTRIES];
  cache_pkg::tlb_entry_t   rd_q;
  logic [`VPN_TAG_W-1:0]   vtag_q;
  logic [`LINE_IDX_W-1:0]  sweep_cnt;

  // ------------------------------
  // reset sweep
  // ------------------------------
  // walks one step per line so the tag store finishes in step
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      sweep_cnt  <= '0;
      sweep_done <= 1'b0;
    end
    else if (!sweep_done)
    begin
      sweep_cnt <= sweep_cnt + 1'b1;
      if (sweep_cnt == {`LINE_IDX_W{1'b1}})
        sweep_done <= 1'b1;
    end
  end

  // ------------------------------
  // translation RAM
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!sweep_done)
      ram[sweep_cnt[`TLB_IDX_W-1:0]] <= '0;
    else if (load_we)
      ram[load_vaddr] <= load_pte;
  end

  // registered read plus the tag it is checked against
  always_ff @(posedge CPU_CLK)
  begin
    rd_q   <= ram[lookup_vaddr[`VPN_TAG_LSB-1:`PAGE_OFS_W]];
    vtag_q <= lookup_vaddr[`VADDR_W-1:`VPN_TAG_LSB];
  end

  assign tlb_hit   = rd_q.valid && (rd_q.vtag == vtag_q);
  assign phys_page = rd_q.ppn;

  // loads are held off by tlb_busy in the controller
  a_load_after_sweep : assert property (@(posedge CPU_CLK) disable iff (!RST)
    load_we |-> sweep_done);

endmodule

/* logic/cache_pkg.sv */
`include "cache_macros.svh"

package cache_pkg;

  // ------------------------------
  // enums
  // ------------------------------

  // memory port operations
  typedef enum logic
  {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // controller states
  typedef enum logic [2:0]
  {
    ST_IDLE      = 3'd0,
    ST_LOOKUP    = 3'd1,
    ST_REFILL0   = 3'd2,
    ST_REFILL1   = 3'd3,
    ST_FILL_DONE = 3'd4,
    ST_WRITE     = 3'd5,
    ST_RESP      = 3'd6
  } ctrl_state_e;

  // ------------------------------
  // structs
  // ------------------------------

  // latched cpu request
  typedef struct packed
  {
    logic [`VADDR_W-1:0] vaddr;
    logic [31:0]         wdata;
    logic                we;
  } cpu_req_t;

  // one translation, vtag is vaddr 31:16
  typedef struct packed
  {
    logic                  valid;
    logic [`VPN_TAG_W-1:0] vtag;
    logic [`PPN_W-1:0]     ppn;
  } tlb_entry_t;

  // line index sits inside the page offset, so the page number is the tag
  typedef struct packed
  {
    logic              valid;
    logic [`PPN_W-1:0] tag;
  } tag_entry_t;

  // one word access on the memory bus
  typedef struct packed
  {
    mem_op_e                op;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [31:0]            data;
  } mem_req_t;

endpackage

/* include/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ------------------------------
// virtual address split
// ------------------------------
`define VADDR_W         32
`define VPN_TAG_W       16
`define VPN_TAG_LSB     (`VADDR_W - `VPN_TAG_W)

// physical side
`define PPN_W           16
`define PADDR_W         26
`define PAGE_OFS_W      (`PADDR_W - `PPN_W)
`define MEM_ADDR_W      (`PADDR_W - 2)

// ------------------------------
// RAM geometry
// ------------------------------
`define TLB_ENTRIES     64
`define TLB_IDX_W       6
`define CACHE_LINES     128
`define LINE_IDX_W      7
`define LINE_IDX_LSB    3
`define WORDS_PER_LINE  2
`define DATA_WORDS      (`CACHE_LINES * `WORDS_PER_LINE)
`define DATA_ADDR_W     8

`endif
